// ==== logic/fe_config.svh ====
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// instruction queue entries
`define FE_QUEUE_DEPTH 8

`define FE_RESET_PC 32'h0000_0000

// opcode field values, inst[31:15]
`define FE_OP_ADD_W   17'h00020
`define FE_OP_SUB_W   17'h00022
`define FE_OP_AND     17'h00029
`define FE_OP_OR      17'h0002a
// inst[31:22]
`define FE_OP_ADDI_W  10'h00a
`define FE_OP_ST_W    10'h0a6
// inst[31:25]
`define FE_OP_LU12I_W 7'h0a
// inst[31:26]
`define FE_OP_BEQ     6'h16
`define FE_OP_BL      6'h15

`endif

// ==== logic/fe_pkg.sv ====
package fe_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_id_t;
  typedef logic [1:0]  slot_mask_t;

  // where a read port takes its register number
  typedef enum logic [1:0] {
    rsel_none,
    rsel_rd,
    rsel_rj,
    rsel_rk
  } rd_sel_e;

  typedef enum logic [1:0] {
    wsel_none,
    wsel_rd,
    wsel_link
  } wr_sel_e;

  typedef struct packed {
    addr_t      pc;
    slot_mask_t mask;
  } fetch_req_t;

  typedef struct packed {
    addr_t       pc;
    inst_t [1:0] inst;
    slot_mask_t  mask;
  } fetch_pkt_t;

  typedef struct packed {
    addr_t         pc;
    inst_t         inst;
    reg_id_t [1:0] rs;
    reg_id_t       rd;
    logic          invalid;
  } slot_info_t;

  typedef struct packed {
    slot_info_t [1:0] slot;
    slot_mask_t       mask;
  } decode_pkt_t;

endpackage

// ==== logic/fe_pcgen.sv ====
`include "fe_config.svh"

module fe_pcgen
  import fe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       redirect_valid_i,
  input  addr_t      redirect_pc_i,
  input  logic       req_ready_i,
  output logic       req_valid_o,
  output fetch_req_t req_o
);

  localparam addr_t RESET_PC = `FE_RESET_PC;

  addr_t      pc_q;
  slot_mask_t mask_q;
  logic       valid_q;

  // target in the upper word leaves slot 0 empty
  function automatic slot_mask_t entry_mask(input addr_t pc);
    return pc[2] ? 2'b10 : 2'b11;
  endfunction

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      pc_q    <= {RESET_PC[31:2], 2'b00};
      mask_q  <= entry_mask(RESET_PC);
    end
    else if (redirect_valid_i)
    begin
      valid_q <= 1'b1;
      pc_q    <= {redirect_pc_i[31:2], 2'b00};
      mask_q  <= entry_mask(redirect_pc_i);
    end
    else
    begin
      valid_q <= 1'b1;
      if (valid_q && req_ready_i)
      begin
        pc_q   <= {pc_q[31:3] + 29'd1, 3'b000};
        mask_q <= 2'b11;
      end
    end
  end

  assign req_valid_o = valid_q;
  assign req_o.pc    = pc_q;
  assign req_o.mask  = mask_q;

endmodule

// ==== logic/fe_fetch.sv ====
module fe_fetch
  import fe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  input  logic       req_valid_i,
  input  fetch_req_t req_i,
  input  logic       pkt_ready_i,
  input  inst_t      wb_dat_i,
  input  logic       wb_ack_i,
  output logic       req_ready_o,
  output logic       pkt_valid_o,
  output fetch_pkt_t pkt_o,
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output logic       wb_we_o,
  output addr_t      wb_adr_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_first,
    st_rd_second,
    st_hold,
    st_drain
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  fetch_req_t   req_q;
  inst_t [1:0]  inst_q;
  addr_t        adr_q;
  logic         req_take;
  logic         bus_busy;

  assign req_ready_o = (state_q == st_idle) && !flush_i;
  assign req_take    = req_valid_i && req_ready_o;
  assign bus_busy    = state_q inside {st_rd_first, st_rd_second, st_drain};

  assign wb_cyc_o = bus_busy;
  assign wb_stb_o = bus_busy;
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
        if (req_take)
          state_d = req_i.mask[0] ? st_rd_first : st_rd_second;
      st_rd_first:
        if (wb_ack_i)
          state_d = flush_i ? st_idle : (req_q.mask[1] ? st_rd_second : st_hold);
        else if (flush_i)
          state_d = st_drain;
      st_rd_second:
        if (wb_ack_i)
          state_d = flush_i ? st_idle : st_hold;
        else if (flush_i)
          state_d = st_drain;
      st_hold:
        if (flush_i || pkt_ready_i)
          state_d = st_idle;
      // orphaned read, wait out its ack
      st_drain:
        if (wb_ack_i)
          state_d = st_idle;
      default:
        state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (req_take)
    begin
      req_q <= req_i;
      adr_q <= {req_i.pc[31:3], !req_i.mask[0], 2'b00};
    end
    if (wb_ack_i && state_q == st_rd_first)
    begin
      inst_q[0] <= wb_dat_i;
      adr_q     <= {req_q.pc[31:3], 3'b100};
    end
    if (wb_ack_i && state_q == st_rd_second)
    begin
      // single upper word moves down to slot 0
      if (req_q.mask[0])
        inst_q[1] <= wb_dat_i;
      else
        inst_q[0] <= wb_dat_i;
    end
  end

  assign pkt_valid_o = (state_q == st_hold);

  always_comb
  begin
    pkt_o.pc      = {req_q.pc[31:3], !req_q.mask[0], 2'b00};
    pkt_o.inst[0] = inst_q[0];
    pkt_o.inst[1] = req_q.mask[0] ? inst_q[1] : '0;
    pkt_o.mask    = req_q.mask[0] ? req_q.mask : 2'b01;
  end

endmodule

// ==== logic/fe_decoder.sv ====
`include "fe_config.svh"

module fe_decoder
  import fe_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        pkt_valid_i,
  input  fetch_pkt_t  pkt_i,
  input  logic        dec_ready_i,
  output logic        pkt_ready_o,
  output logic        dec_valid_o,
  output decode_pkt_t dec_o
);

  decode_pkt_t dec_d;
  decode_pkt_t dec_q;
  logic        valid_q;

  function automatic reg_id_t pick_src(input rd_sel_e sel, input inst_t inst);
    case (sel)
      rsel_rd: return inst[4:0];
      rsel_rj: return inst[9:5];
      rsel_rk: return inst[14:10];
      default: return '0;
    endcase
  endfunction

  function automatic slot_info_t decode_slot(input addr_t pc, input inst_t inst);
    slot_info_t info;
    rd_sel_e    src0;
    rd_sel_e    src1;
    wr_sel_e    dst;
    logic       bad;
    src0 = rsel_none;
    src1 = rsel_none;
    dst  = wsel_none;
    bad  = 1'b0;
    if (inst[31:15] == `FE_OP_ADD_W || inst[31:15] == `FE_OP_SUB_W ||
        inst[31:15] == `FE_OP_AND || inst[31:15] == `FE_OP_OR)
    begin
      src0 = rsel_rj;
      src1 = rsel_rk;
      dst  = wsel_rd;
    end
    else if (inst[31:22] == `FE_OP_ADDI_W)
    begin
      src0 = rsel_rj;
      dst  = wsel_rd;
    end
    else if (inst[31:25] == `FE_OP_LU12I_W)
      dst = wsel_rd;
    // store data and second branch operand sit in rd
    else if (inst[31:22] == `FE_OP_ST_W || inst[31:26] == `FE_OP_BEQ)
    begin
      src0 = rsel_rj;
      src1 = rsel_rd;
    end
    else if (inst[31:26] == `FE_OP_BL)
      dst = wsel_link;
    else
      bad = 1'b1;
    info.pc    = pc;
    info.inst  = inst;
    info.rs[0] = pick_src(src0, inst);
    info.rs[1] = pick_src(src1, inst);
    case (dst)
      wsel_rd:   info.rd = inst[4:0];
      wsel_link: info.rd = 5'd1;
      default:   info.rd = '0;
    endcase
    info.invalid = bad;
    return info;
  endfunction

  for (genvar i = 0; i < 2; i++)
  begin : gen_slot
    addr_t slot_pc;
    assign slot_pc = (i == 0) ? pkt_i.pc : {pkt_i.pc[31:3], 1'b1, pkt_i.pc[1:0]};
    assign dec_d.slot[i] = decode_slot(slot_pc, pkt_i.inst[i]);
  end
  assign dec_d.mask = pkt_i.mask;

  assign pkt_ready_o = !valid_q || dec_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      valid_q <= 1'b0;
    else if (pkt_ready_o)
      valid_q <= pkt_valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (pkt_valid_i && pkt_ready_o)
      dec_q <= dec_d;
  end

  assign dec_valid_o = valid_q;
  assign dec_o       = dec_q;

endmodule

// ==== logic/fe_fifo.sv ====
`include "fe_config.svh"

module fe_fifo
  import fe_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        in_valid_i,
  input  decode_pkt_t in_i,
  input  logic        out_ready_i,
  output logic        in_ready_o,
  output logic        out_valid_o,
  output decode_pkt_t out_o
);

  localparam int DEPTH = `FE_QUEUE_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  decode_pkt_t   mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  // wraps for any depth, not just powers of two
  function automatic logic [PW-1:0] bump(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != CW'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_o       = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= bump(wr_ptr_q);
      if (pop)
        rd_ptr_q <= bump(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem_q[wr_ptr_q] <= in_i;
  end

endmodule

// ==== logic/fe_frontend.sv ====
module fe_frontend
  import fe_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_valid_i,
  input  addr_t            redirect_pc_i,
  input  logic             pack_ready_i,
  input  inst_t            wb_dat_i,
  input  logic             wb_ack_i,
  output logic             pack_valid_o,
  output slot_info_t [1:0] pack_o,
  output slot_mask_t       pack_mask_o,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic             wb_we_o,
  output addr_t            wb_adr_o
);

  fetch_req_t  pc_req;
  logic        pc_req_valid;
  logic        pc_req_ready;

  fetch_pkt_t  fetch_pkt;
  logic        fetch_valid;
  logic        fetch_ready;

  decode_pkt_t dec_pkt;
  logic        dec_valid;
  logic        dec_ready;

  decode_pkt_t queue_out;

  fe_pcgen i_pcgen (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_ready_i      (pc_req_ready),
    .req_valid_o      (pc_req_valid),
    .req_o            (pc_req)
  );

  fe_fetch i_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_valid_i),
    .req_valid_i (pc_req_valid),
    .req_i       (pc_req),
    .pkt_ready_i (fetch_ready),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .req_ready_o (pc_req_ready),
    .pkt_valid_o (fetch_valid),
    .pkt_o       (fetch_pkt),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o)
  );

  fe_decoder i_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_valid_i),
    .pkt_valid_i (fetch_valid),
    .pkt_i       (fetch_pkt),
    .dec_ready_i (dec_ready),
    .pkt_ready_o (fetch_ready),
    .dec_valid_o (dec_valid),
    .dec_o       (dec_pkt)
  );

  // output queue toward the back end
  fe_fifo i_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_valid_i),
    .in_valid_i  (dec_valid),
    .in_i        (dec_pkt),
    .out_ready_i (pack_ready_i),
    .in_ready_o  (dec_ready),
    .out_valid_o (pack_valid_o),
    .out_o       (queue_out)
  );

  assign pack_o      = queue_out.slot;
  assign pack_mask_o = queue_out.mask;

endmodule

// ==== verif/fe_wb_mem.sv ====
module fe_wb_mem
  import fe_pkg::*;
#(
  parameter int WORDS = 32
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  inst_t [WORDS-1:0] image_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  addr_t             wb_adr_i,
  output inst_t             wb_dat_o,
  output logic              wb_ack_o
);

  localparam int AW = $clog2(WORDS);

  logic [1:0] wait_q;

  // outside the image every word carries an unused opcode
  function automatic inst_t read_word(input addr_t adr);
    if ({2'b00, adr[31:2]} < 32'(WORDS))
      return image_i[adr[AW+1:2]];
    return {6'h3f, adr[27:2] ^ {22'h0, adr[31:28]}};
  endfunction

  // read only, one ack per request
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
      wait_q   <= 2'd0;
    end
    else if (wb_ack_o)
      wb_ack_o <= 1'b0;
    else if (wb_cyc_i && wb_stb_i && !wb_we_i)
    begin
      if (wait_q == 2'd0)
      begin
        wb_ack_o <= 1'b1;
        wb_dat_o <= read_word(wb_adr_i);
        wait_q   <= 2'($urandom % 4);
      end
      else
        wait_q <= wait_q - 2'd1;
    end
  end

endmodule

// ==== verif/fe_frontend_properties.sv ====
module fe_frontend_properties
  import fe_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input logic             redirect_valid_i,
  input logic             wb_cyc_i,
  input logic             wb_stb_i,
  input logic             wb_ack_i,
  input addr_t            wb_adr_i,
  input logic             pack_valid_i,
  input logic             pack_ready_i,
  input slot_info_t [1:0] pack_i,
  input slot_mask_t       pack_mask_i
);

  // a read stays on the bus, inside its cycle, until its ack
  stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && wb_cyc_i))
    else $error("wishbone request dropped before ack");

  // request held until its ack
  adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_i && !wb_ack_i) |=> $stable(wb_adr_i))
    else $error("wishbone address changed before ack");

  pack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (pack_valid_i && !pack_ready_i && !redirect_valid_i)
      |=> (pack_valid_i && $stable(pack_i) && $stable(pack_mask_i)))
    else $error("output packet changed while stalled");

  reset_quiet: assert property (@(posedge clk) !rst_n |=> (!wb_cyc_i && !pack_valid_i))
    else $error("bus or output active during reset");

endmodule

bind fe_frontend fe_frontend_properties i_props (
  .clk              (clk),
  .rst_n            (rst_n),
  .redirect_valid_i (redirect_valid_i),
  .wb_cyc_i         (wb_cyc_o),
  .wb_stb_i         (wb_stb_o),
  .wb_ack_i         (wb_ack_i),
  .wb_adr_i         (wb_adr_o),
  .pack_valid_i     (pack_valid_o),
  .pack_ready_i     (pack_ready_i),
  .pack_i           (pack_o),
  .pack_mask_i      (pack_mask_o)
);

// ==== verif/fe_frontend_tb.sv ====
`include "fe_config.svh"

module fe_frontend_tb
  import fe_pkg::*;
();

  localparam int    TABLE_LEN   = 32;
  localparam addr_t TABLE_END   = 32'(TABLE_LEN * 4);
  localparam int    CYCLE_LIMIT = TABLE_LEN * 8 + `FE_QUEUE_DEPTH + 100;

  typedef struct packed {
    inst_t   inst;
    reg_id_t rs0;
    reg_id_t rs1;
    reg_id_t rd;
    logic    bad;
  } row_t;

  logic                       clk;
  logic                       rst_n;
  logic                       redirect_valid_i;
  addr_t                      redirect_pc_i;
  logic                       pack_ready_i;
  logic                       pack_valid_o;
  slot_info_t [1:0]           pack_o;
  slot_mask_t                 pack_mask_o;
  logic                       wb_cyc_o;
  logic                       wb_stb_o;
  logic                       wb_we_o;
  addr_t                      wb_adr_o;
  inst_t                      wb_dat_i;
  logic                       wb_ack_i;
  row_t                       table_q [TABLE_LEN];
  inst_t [TABLE_LEN-1:0]      image;
  addr_t                      exp_pc;
  int                         mismatches = 0;
  int                         failures = 0;
  int                         phase = 0;
  int                         seen_phase = 0;
  int                         cycles = 0;

  fe_frontend i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .pack_ready_i     (pack_ready_i),
    .wb_dat_i         (wb_dat_i),
    .wb_ack_i         (wb_ack_i),
    .pack_valid_o     (pack_valid_o),
    .pack_o           (pack_o),
    .pack_mask_o      (pack_mask_o),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_we_o          (wb_we_o),
    .wb_adr_o         (wb_adr_o)
  );

  fe_wb_mem #(.WORDS(TABLE_LEN)) i_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .image_i  (image),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack_o (wb_ack_i)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic inst_t encode_3r(input logic [16:0] op, input reg_id_t rd,
                                      input reg_id_t rj, input reg_id_t rk);
    return {op, rk, rj, rd};
  endfunction

  function automatic inst_t encode_ri12(input logic [9:0] op, input reg_id_t rd,
                                        input reg_id_t rj, input logic [11:0] imm);
    return {op, imm, rj, rd};
  endfunction

  function automatic inst_t encode_ri16(input logic [5:0] op, input reg_id_t rd,
                                        input reg_id_t rj, input logic [15:0] offs);
    return {op, offs, rj, rd};
  endfunction

  function automatic inst_t encode_ri20(input logic [6:0] op, input reg_id_t rd,
                                        input logic [19:0] imm);
    return {op, imm, rd};
  endfunction

  task automatic set_row(input int idx, input inst_t inst, input int rs0, input int rs1,
                         input int rd, input int bad);
    table_q[idx].inst = inst;
    table_q[idx].rs0  = 5'(rs0);
    table_q[idx].rs1  = 5'(rs1);
    table_q[idx].rd   = 5'(rd);
    table_q[idx].bad  = (bad != 0);
    image[idx]        = inst;
  endtask

  // expected columns: read 0, read 1, write, invalid
  task automatic build_table();
    set_row(0,  encode_3r(`FE_OP_ADD_W, 5'd3, 5'd1, 5'd2), 1, 2, 3, 0);
    set_row(1,  encode_3r(`FE_OP_SUB_W, 5'd4, 5'd3, 5'd1), 3, 1, 4, 0);
    set_row(2,  encode_3r(`FE_OP_AND, 5'd5, 5'd4, 5'd3), 4, 3, 5, 0);
    set_row(3,  encode_3r(`FE_OP_OR, 5'd6, 5'd5, 5'd4), 5, 4, 6, 0);
    set_row(4,  encode_ri12(`FE_OP_ADDI_W, 5'd7, 5'd6, 12'h010), 6, 0, 7, 0);
    set_row(5,  encode_ri20(`FE_OP_LU12I_W, 5'd8, 20'h12345), 0, 0, 8, 0);
    set_row(6,  encode_ri12(`FE_OP_ST_W, 5'd9, 5'd8, 12'h004), 8, 9, 0, 0);
    set_row(7,  encode_ri16(`FE_OP_BEQ, 5'd11, 5'd10, 16'h0004), 10, 11, 0, 0);
    set_row(8,  {`FE_OP_BL, 26'h000_0010}, 0, 0, 1, 0);
    set_row(9,  32'hffff_ffff, 0, 0, 0, 1);
    set_row(10, encode_3r(`FE_OP_ADD_W, 5'd31, 5'd30, 5'd29), 30, 29, 31, 0);
    set_row(11, encode_ri12(`FE_OP_ADDI_W, 5'd0, 5'd0, 12'h000), 0, 0, 0, 0);
    set_row(12, encode_3r(`FE_OP_SUB_W, 5'd12, 5'd13, 5'd14), 13, 14, 12, 0);
    set_row(13, encode_3r(`FE_OP_OR, 5'd15, 5'd16, 5'd17), 16, 17, 15, 0);
    set_row(14, encode_ri12(`FE_OP_ST_W, 5'd18, 5'd19, 12'hffc), 19, 18, 0, 0);
    set_row(15, 32'h0000_0000, 0, 0, 0, 1);
    set_row(16, encode_ri20(`FE_OP_LU12I_W, 5'd20, 20'hfffff), 0, 0, 20, 0);
    set_row(17, encode_3r(`FE_OP_AND, 5'd21, 5'd22, 5'd23), 22, 23, 21, 0);
    set_row(18, encode_ri16(`FE_OP_BEQ, 5'd25, 5'd24, 16'hfff0), 24, 25, 0, 0);
    set_row(19, encode_ri12(`FE_OP_ADDI_W, 5'd26, 5'd27, 12'h7ff), 27, 0, 26, 0);
    set_row(20, {`FE_OP_BL, 26'h3ff_ffff}, 0, 0, 1, 0);
    set_row(21, encode_3r(`FE_OP_ADD_W, 5'd28, 5'd29, 5'd30), 29, 30, 28, 0);
    set_row(22, 32'hdead_beef, 0, 0, 0, 1);
    set_row(23, encode_3r(`FE_OP_SUB_W, 5'd1, 5'd2, 5'd3), 2, 3, 1, 0);
    set_row(24, encode_3r(`FE_OP_OR, 5'd2, 5'd0, 5'd1), 0, 1, 2, 0);
    set_row(25, encode_ri12(`FE_OP_ST_W, 5'd3, 5'd4, 12'h000), 4, 3, 0, 0);
    set_row(26, encode_ri12(`FE_OP_ADDI_W, 5'd5, 5'd5, 12'h001), 5, 0, 5, 0);
    set_row(27, encode_ri20(`FE_OP_LU12I_W, 5'd6, 20'h00001), 0, 0, 6, 0);
    set_row(28, encode_ri16(`FE_OP_BEQ, 5'd8, 5'd7, 16'h0008), 7, 8, 0, 0);
    set_row(29, encode_3r(`FE_OP_AND, 5'd9, 5'd10, 5'd11), 10, 11, 9, 0);
    set_row(30, {`FE_OP_BL, 26'h000_0004}, 0, 0, 1, 0);
    set_row(31, encode_3r(`FE_OP_ADD_W, 5'd13, 5'd14, 5'd15), 14, 15, 13, 0);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("mismatches %0d, other failures %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  task automatic check_idle();
    check("pack_valid_o", 32'(pack_valid_o), 32'd0);
    check("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
  endtask

  // walk the valid slots of the packet leaving on the next edge
  task automatic take_packet();
    slot_mask_t exp_mask;
    int         idx;
    exp_mask = exp_pc[2] ? 2'b01 : 2'b11;
    check("pack_mask_o", 32'(pack_mask_o), 32'(exp_mask));
    for (int s = 0; s < 2; s++)
    begin
      if (pack_mask_o[s])
      begin
        idx = int'(exp_pc >> 2);
        check($sformatf("pack_o[%0d].pc", s), pack_o[s].pc, exp_pc);
        if (idx < TABLE_LEN)
        begin
          check($sformatf("pack_o[%0d].inst", s), pack_o[s].inst, table_q[idx].inst);
          check($sformatf("pack_o[%0d].rs[0]", s), 32'(pack_o[s].rs[0]),
                32'(table_q[idx].rs0));
          check($sformatf("pack_o[%0d].rs[1]", s), 32'(pack_o[s].rs[1]),
                32'(table_q[idx].rs1));
          check($sformatf("pack_o[%0d].rd", s), 32'(pack_o[s].rd), 32'(table_q[idx].rd));
          check($sformatf("pack_o[%0d].invalid", s), 32'(pack_o[s].invalid),
                32'(table_q[idx].bad));
        end
        exp_pc = exp_pc + 32'd4;
      end
    end
  endtask

  task automatic run_stream(input addr_t start, input logic random_ready);
    exp_pc = start;
    phase++;
    while (exp_pc < TABLE_END)
    begin
      @(negedge clk);
      // the port only ever reads
      check("wb_we_o", 32'(wb_we_o), 32'd0);
      pack_ready_i = random_ready ? 1'($urandom % 2) : 1'b1;
      if (pack_valid_o && pack_ready_i)
        take_packet();
    end
  endtask

  // queue is full once its input stalls
  task automatic fill_queue();
    phase++;
    @(negedge clk);
    pack_ready_i = 1'b0;
    while (i_dut.dec_ready)
      @(negedge clk);
  endtask

  task automatic redirect_to(input addr_t target);
    @(negedge clk);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    @(negedge clk);
    redirect_valid_i = 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (phase != seen_phase)
    begin
      seen_phase = phase;
      cycles     = 0;
    end
    else
      cycles++;
    if (cycles == CYCLE_LIMIT)
    begin
      failures++;
      $display("output stopped: phase %0d made no progress in %0d cycles", phase, cycles);
      report_and_finish();
    end
  end

  initial
  begin
    void'($urandom(32'ha0487eee));
    rst_n            = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    pack_ready_i     = 1'b0;
    build_table();
    repeat (8)
    begin
      @(negedge clk);
      check_idle();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    run_stream(`FE_RESET_PC, 1'b0);
    fill_queue();
    redirect_to(32'h0000_0000);
    run_stream(32'h0000_0000, 1'b1);
    // upper word target, first packet carries one slot
    fill_queue();
    redirect_to(32'h0000_0024);
    run_stream(32'h0000_0024, 1'b1);
    report_and_finish();
  end

endmodule

// ==== project.f ====
+incdir+logic
logic/fe_pkg.sv
logic/fe_pcgen.sv
logic/fe_fetch.sv
logic/fe_decoder.sv
logic/fe_fifo.sv
logic/fe_frontend.sv
verif/fe_wb_mem.sv
verif/fe_frontend_properties.sv
verif/fe_frontend_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = fe_frontend_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
